//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_sched_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf $(OBJ_DIR)

//--- sources.f
+incdir+include
src/sched_cfg_pkg.sv
src/sched_regs_pkg.sv
src/egress_scheduler.sv
src/queue_store.sv
src/sched_apb_regs.sv
src/sched_top.sv
test/tb_sched_top.sv

//--- src/egress_scheduler.sv
////////////////////////////////////////
// One dequeue request per selected port
// A port stays locked to its queue until the last word is done
////////////////////////////////////////

`timescale 1ns/10ps

module egress_scheduler (
    input  logic                                    dequeue_notification,
    input  logic                                    rst_n,
    input  logic [sched_cfg_pkg::num_queues-1:0]    queue_empty,
    input  logic [sched_cfg_pkg::num_egr_ports-1:0] port_enable,
    input  logic [sched_cfg_pkg::num_egr_ports-1:0] egr_buf_ready,
    input  logic                                    word_done_valid,
    input  logic                                    word_done_last,
    input  sched_cfg_pkg::qid_u                     word_done_qid,
    output logic                                    deq_valid,
    output sched_cfg_pkg::qid_u                     deq_qid
);
    import sched_cfg_pkg::*;

    ////////////////////////////////////////
    // Declarations

    logic [num_egr_ports-1:0]   port_empty;
    logic [num_egr_ports-1:0]   in_flight;
    logic [num_egr_ports-1:0]   port_ok;
    logic [dq_latency:0]        flight_pipe [num_egr_ports];

    logic [port_w-1:0]          sel_port;
    logic                       sel_valid;
    logic [port_w-1:0]          rr_cand;
    logic [port_w-1:0]          rr_port;
    logic                       rr_found;

    logic [queues_per_port-1:0] sel_empty;
    logic [prio_w-1:0]          top_prio;
    logic                       top_found;

    logic [num_egr_ports-1:0]   pkt_lock;
    logic [prio_w-1:0]          active_prio [num_egr_ports];

    ////////////////////////////////////////
    // Port qualification

    always_comb begin
        for (int p = 0; p < num_egr_ports; p++) begin
            port_empty[p] = &queue_empty[p*queues_per_port +: queues_per_port];
            in_flight[p]  = |flight_pipe[p];
            port_ok[p]    = !port_empty[p] && !in_flight[p] &&
                            port_enable[p] && egr_buf_ready[p];
        end
    end

    // Scan starts at the last selected port, first hit wins
    always_comb begin
        rr_cand  = sel_port;
        rr_port  = sel_port;
        rr_found = 1'b0;
        for (int i = 0; i < num_egr_ports; i++) begin
            rr_cand = sel_port + port_w'(i);
            if (!rr_found && port_ok[rr_cand]) begin
                rr_port  = rr_cand;
                rr_found = 1'b1;
            end
        end
    end

    // Highest non-empty queue of the selected port
    always_comb begin
        sel_empty = queue_empty[sel_port*queues_per_port +: queues_per_port];
        top_prio  = '0;
        top_found = 1'b0;
        for (int q = queues_per_port - 1; q >= 0; q--) begin
            if (!top_found && !sel_empty[q]) begin
                top_prio  = prio_w'(q);
                top_found = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Selection, lock and request

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            sel_port    <= '0;
            sel_valid   <= 1'b0;
            deq_valid   <= 1'b0;
            pkt_lock    <= '0;
            flight_pipe <= '{default: '0};
        end else begin
            for (int p = 0; p < num_egr_ports; p++) begin
                flight_pipe[p] <= {flight_pipe[p][dq_latency-1:0], 1'b0};
            end

            sel_valid <= rr_found;
            if (rr_found) begin
                sel_port                 <= rr_port;
                flight_pipe[rr_port][0]  <= 1'b1;
            end

            // Last word of a packet frees its port
            if (word_done_valid && word_done_last) begin
                pkt_lock[word_done_qid.pp.port] <= 1'b0;
            end

            deq_valid <= 1'b0;
            if (sel_valid) begin
                if (pkt_lock[sel_port]) begin
                    deq_valid <= 1'b1;
                end else if (top_found) begin
                    deq_valid          <= 1'b1;
                    pkt_lock[sel_port] <= 1'b1;
                end
            end
        end
    end

    // Queue id and remembered priority
    always_ff @(posedge dequeue_notification) begin
        if (sel_valid) begin
            deq_qid.pp.port <= sel_port;
            if (pkt_lock[sel_port]) begin
                deq_qid.pp.prio <= active_prio[sel_port];
            end else begin
                deq_qid.pp.prio <= top_prio;
                if (top_found) begin
                    active_prio[sel_port] <= top_prio;
                end
            end
        end
    end

endmodule

//--- src/queue_store.sv
////////////////////////////////////////
// Requests to an empty queue are dropped
// Head descriptor pops when its last word is requested
////////////////////////////////////////

`timescale 1ns/10ps

module queue_store (
    input  logic                                 dequeue_notification,
    input  logic                                 rst_n,
    input  logic                                 enq_valid,
    input  sched_cfg_pkg::qid_u                  enq_qid,
    input  logic [sched_cfg_pkg::len_w-1:0]      enq_len,
    output logic                                 enq_ready,
    output logic [sched_cfg_pkg::num_queues-1:0] queue_empty,
    input  logic                                 deq_valid,
    input  sched_cfg_pkg::qid_u                  deq_qid,
    output logic                                 word_done_valid,
    output sched_cfg_pkg::qid_u                  word_done_qid,
    output logic                                 word_done_last
);
    import sched_cfg_pkg::*;

    ////////////////////////////////////////
    // Declarations

    logic [len_w-1:0]      len_mem   [num_queues][fifo_depth];
    logic [fifo_ptr_w-1:0] rd_ptr    [num_queues];
    logic [fifo_ptr_w-1:0] wr_ptr    [num_queues];
    logic [fifo_cnt_w-1:0] fill      [num_queues];
    logic [len_w-1:0]      words_out [num_queues];

    logic                  store_up;
    logic                  push;
    logic                  req_ok;
    logic                  req_last;
    logic                  pop;
    logic [num_queues-1:0] push_sel;
    logic [num_queues-1:0] pop_sel;

    logic [dq_latency-1:0] done_v_pipe;
    logic [dq_latency-1:0] done_l_pipe;
    qid_u                  done_q_pipe [dq_latency];

    ////////////////////////////////////////
    // Flags and request decode

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            queue_empty[q] = (fill[q] == '0);
        end
    end

    assign enq_ready = store_up && (fill[enq_qid.flat] != fifo_cnt_w'(fifo_depth));
    assign push      = enq_valid && enq_ready;

    // Last when words already sent reach the stored length minus one
    assign req_ok   = deq_valid && !queue_empty[deq_qid.flat];
    assign req_last = (words_out[deq_qid.flat] == len_mem[deq_qid.flat][rd_ptr[deq_qid.flat]]);
    assign pop      = req_ok && req_last;

    always_comb begin
        push_sel               = '0;
        pop_sel                = '0;
        push_sel[enq_qid.flat] = push;
        pop_sel[deq_qid.flat]  = pop;
    end

    ////////////////////////////////////////
    // FIFO control

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            store_up  <= 1'b0;
            rd_ptr    <= '{default: '0};
            wr_ptr    <= '{default: '0};
            fill      <= '{default: '0};
            words_out <= '{default: '0};
        end else begin
            store_up <= 1'b1;
            for (int q = 0; q < num_queues; q++) begin
                if (push_sel[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop_sel[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                if (push_sel[q] && !pop_sel[q]) begin
                    fill[q] <= fill[q] + 1'b1;
                end else if (!push_sel[q] && pop_sel[q]) begin
                    fill[q] <= fill[q] - 1'b1;
                end
            end
            if (req_ok) begin
                words_out[deq_qid.flat] <= req_last ? '0 : words_out[deq_qid.flat] + 1'b1;
            end
        end
    end

    always_ff @(posedge dequeue_notification) begin
        if (push) begin
            len_mem[enq_qid.flat][wr_ptr[enq_qid.flat]] <= enq_len;
        end
    end

    ////////////////////////////////////////
    // Done stream delay line

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            done_v_pipe <= '0;
            done_l_pipe <= '0;
        end else begin
            done_v_pipe <= {done_v_pipe[dq_latency-2:0], req_ok};
            done_l_pipe <= {done_l_pipe[dq_latency-2:0], pop};
        end
    end

    always_ff @(posedge dequeue_notification) begin
        done_q_pipe[0] <= deq_qid;
        for (int s = 1; s < dq_latency; s++) begin
            done_q_pipe[s] <= done_q_pipe[s-1];
        end
    end

    assign word_done_valid = done_v_pipe[dq_latency-1];
    assign word_done_last  = done_l_pipe[dq_latency-1];
    assign word_done_qid   = done_q_pipe[dq_latency-1];

endmodule

//--- src/sched_apb_regs.sv
////////////////////////////////////////
// No wait states, counters are read only
////////////////////////////////////////

`timescale 1ns/10ps

module sched_apb_regs (
    input  logic                                    dequeue_notification,
    input  logic                                    rst_n,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [sched_regs_pkg::apb_addr_w-1:0]   paddr,
    input  logic [sched_regs_pkg::apb_data_w-1:0]   pwdata,
    output logic [sched_regs_pkg::apb_data_w-1:0]   prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic [sched_cfg_pkg::num_egr_ports-1:0] port_enable,
    input  logic                                    word_done_valid,
    input  sched_cfg_pkg::qid_u                     word_done_qid
);
    import sched_cfg_pkg::*;
    import sched_regs_pkg::*;

    logic [cnt_w-1:0]      words_sent [num_egr_ports];
    logic                  access;
    logic                  hit_enable;
    logic                  hit_counter;
    logic [apb_addr_w-1:0] cnt_offset;
    logic [port_w-1:0]     cnt_idx;

    ////////////////////////////////////////
    // Address decode

    assign access     = psel && penable;
    assign hit_enable = (paddr == reg_port_enable);

    // Offsets below the base wrap high and miss the window
    assign cnt_offset  = paddr - reg_words_sent_base;
    assign cnt_idx     = cnt_offset[reg_stride_lsb +: port_w];
    assign hit_counter = (cnt_offset < apb_addr_w'(num_egr_ports * reg_stride)) &&
                         (cnt_offset[reg_stride_lsb-1:0] == '0);

    assign pready  = 1'b1;
    assign pslverr = access && ((!hit_enable && !hit_counter) || (pwrite && hit_counter));

    always_comb begin
        prdata = '0;
        if (hit_enable) begin
            prdata = apb_data_w'(port_enable);
        end else if (hit_counter) begin
            prdata = apb_data_w'(words_sent[cnt_idx]);
        end
    end

    ////////////////////////////////////////
    // Enable mask and word counters

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            port_enable <= port_enable_reset[num_egr_ports-1:0];
            words_sent  <= '{default: '0};
        end else begin
            if (access && pwrite && hit_enable) begin
                port_enable <= pwdata[num_egr_ports-1:0];
            end
            // Counters wrap
            if (word_done_valid) begin
                words_sent[word_done_qid.pp.port] <= words_sent[word_done_qid.pp.port] + 1'b1;
            end
        end
    end

endmodule

//--- src/sched_cfg_pkg.sv
////////////////////////////////////////
// Port and queue counts must stay powers of two
// Sizes here are shared by scheduler, store and registers
////////////////////////////////////////

package sched_cfg_pkg;

    // Topology
    localparam int num_egr_ports   = 4;
    localparam int queues_per_port = 4;
    localparam int num_queues      = num_egr_ports * queues_per_port;
    localparam int port_w          = 2;
    localparam int prio_w          = 2;
    localparam int qid_w           = port_w + prio_w;

    // Cycles from dequeue request to word_done
    localparam int dq_latency = 3;

    // Descriptor FIFO per queue
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;
    localparam int fifo_cnt_w = 3;

    // Packet length is stored as words minus one
    localparam int len_w = 2;

    typedef struct packed {
        logic [port_w-1:0] port;
        logic [prio_w-1:0] prio;
    } qid_pp_t;

    // Same four bits seen as flat index or as port and priority
    typedef union packed {
        logic [qid_w-1:0] flat;
        qid_pp_t          pp;
    } qid_u;

endpackage

//--- src/sched_regs_pkg.sv
////////////////////////////////////////
// Register map assumes word aligned accesses
////////////////////////////////////////

package sched_regs_pkg;

    // Bus sizes
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // Register offsets
    localparam logic [apb_addr_w-1:0] reg_port_enable     = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_words_sent_base = 8'h10;

    // One counter per port, 4 bytes apart
    localparam int reg_stride     = 4;
    localparam int reg_stride_lsb = 2;

    // Every port enabled out of reset
    localparam logic [apb_data_w-1:0] port_enable_reset = '1;

    // Sent-word counters wrap at this width
    localparam int cnt_w = 16;

endpackage

//--- src/sched_top.sv
////////////////////////////////////////
// egr_buf_ready and port_enable both gate port selection
////////////////////////////////////////

`timescale 1ns/10ps

module sched_top (
    input  logic                                    dequeue_notification,
    input  logic                                    rst_n,
    input  logic                                    enq_valid,
    input  sched_cfg_pkg::qid_u                     enq_qid,
    input  logic [sched_cfg_pkg::len_w-1:0]         enq_len,
    output logic                                    enq_ready,
    input  logic [sched_cfg_pkg::num_egr_ports-1:0] egr_buf_ready,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [sched_regs_pkg::apb_addr_w-1:0]   paddr,
    input  logic [sched_regs_pkg::apb_data_w-1:0]   pwdata,
    output logic [sched_regs_pkg::apb_data_w-1:0]   prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    word_done_valid,
    output sched_cfg_pkg::qid_u                     word_done_qid,
    output logic                                    word_done_last
);
    import sched_cfg_pkg::*;

    logic [num_queues-1:0]    queue_empty;
    logic                     deq_valid;
    qid_u                     deq_qid;
    logic [num_egr_ports-1:0] port_enable;

    queue_store i_queue_store (
        .dequeue_notification (dequeue_notification),
        .rst_n                (rst_n),
        .enq_valid            (enq_valid),
        .enq_qid              (enq_qid),
        .enq_len              (enq_len),
        .enq_ready            (enq_ready),
        .queue_empty          (queue_empty),
        .deq_valid            (deq_valid),
        .deq_qid              (deq_qid),
        .word_done_valid      (word_done_valid),
        .word_done_qid        (word_done_qid),
        .word_done_last       (word_done_last)
    );

    egress_scheduler i_egress_scheduler (
        .dequeue_notification (dequeue_notification),
        .rst_n                (rst_n),
        .queue_empty          (queue_empty),
        .port_enable          (port_enable),
        .egr_buf_ready        (egr_buf_ready),
        .word_done_valid      (word_done_valid),
        .word_done_last       (word_done_last),
        .word_done_qid        (word_done_qid),
        .deq_valid            (deq_valid),
        .deq_qid              (deq_qid)
    );

    sched_apb_regs i_sched_apb_regs (
        .dequeue_notification (dequeue_notification),
        .rst_n                (rst_n),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .paddr                (paddr),
        .pwdata               (pwdata),
        .prdata               (prdata),
        .pready               (pready),
        .pslverr              (pslverr),
        .port_enable          (port_enable),
        .word_done_valid      (word_done_valid),
        .word_done_qid        (word_done_qid)
    );

endmodule

//--- include/sched_tb_util.svh
////////////////////////////////////////
// Included inside a testbench module body
// The caller owns the LCG state and the check counters
////////////////////////////////////////

`ifndef SCHED_TB_UTIL_SVH
`define SCHED_TB_UTIL_SVH

// Common 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Upper bits are the better random ones
function automatic int unsigned lcg_range(input logic [31:0] state, input int unsigned range);
    return int'(state[31:16]) % range;
endfunction

task automatic check_eq(
    input  string        test_name,
    input  logic [31:0]  expected,
    input  logic [31:0]  actual,
    inout  int unsigned  check_count,
    inout  int unsigned  fail_count
);
    check_count++;
    if (expected !== actual) begin
        $display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
        fail_count++;
    end
endtask

`endif

//--- test/tb_sched_top.sv
////////////////////////////////////////
// Random traffic from a fixed LCG seed, checked against a queue model
// Priority order is checked only while a single port is enabled
////////////////////////////////////////

`timescale 1ns/10ps

module tb_sched_top;
    import sched_cfg_pkg::*;
    import sched_regs_pkg::*;

    `include "sched_tb_util.svh"

    // About 1000 cycles of traffic per test, plus margin
    localparam int max_cycles = 4000;

    logic                     dequeue_notification;
    logic                     rst_n;
    logic                     enq_valid;
    qid_u                     enq_qid;
    logic [len_w-1:0]         enq_len;
    logic                     enq_ready;
    logic [num_egr_ports-1:0] egr_buf_ready;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apb_addr_w-1:0]    paddr;
    logic [apb_data_w-1:0]    pwdata;
    logic [apb_data_w-1:0]    prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     word_done_valid;
    qid_u                     word_done_qid;
    logic                     word_done_last;

    // Reference model state
    int          pend_len [num_queues][$];
    bit          port_busy [num_egr_ports];
    int          port_q [num_egr_ports];
    int          port_words [num_egr_ports];
    int          words_per_port [num_egr_ports];
    logic [31:0] lcg_state;
    int unsigned check_count;
    int unsigned fail_count;
    int unsigned cycle_count;
    string       cur_test;
    bit          strict_on;
    int          strict_port;
    bit          watch_blocked;
    int          blocked_port;
    int          blocked_words;

    sched_top i_sched_top (.*);

    initial begin
        dequeue_notification = 1'b0;
        forever #5 dequeue_notification = ~dequeue_notification;
    end

    always @(posedge dequeue_notification) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Run did not finish within %0d cycles, traffic stalled", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Model helpers

    function automatic int unsigned random_below(input int unsigned range);
        lcg_state = lcg_next(lcg_state);
        return lcg_range(lcg_state, range);
    endfunction

    function automatic int pending_on(input logic [num_egr_ports-1:0] port_mask);
        int total = 0;
        for (int q = 0; q < num_queues; q++) begin
            if (port_mask[q / queues_per_port]) begin
                total += pend_len[q].size();
            end
        end
        return total;
    endfunction

    // Highest priority queue of a port that the model still holds
    function automatic int highest_queue(input int port);
        for (int prio = queues_per_port - 1; prio >= 0; prio--) begin
            if (pend_len[port * queues_per_port + prio].size() != 0) begin
                return port * queues_per_port + prio;
            end
        end
        return -1;
    endfunction

    ////////////////////////////////////////
    // Stimulus tasks

    task automatic wait_idle(input logic [num_egr_ports-1:0] port_mask);
        while (pending_on(port_mask) != 0) begin
            @(negedge dequeue_notification);
        end
    endtask

    task automatic enqueue(input qid_u qid, input int unsigned words);
        @(negedge dequeue_notification);
        enq_valid = 1'b1;
        enq_qid   = qid;
        enq_len   = len_w'(words - 1);
        #1;
        while (!enq_ready) begin
            @(negedge dequeue_notification);
            #1;
        end
        @(negedge dequeue_notification);
        enq_valid = 1'b0;
        pend_len[qid.flat].push_back(words);
        words_per_port[qid.pp.port] += words;
    endtask

    // Queues of ports in guard_mask are never pushed past full
    task automatic load_random(input int count, input logic [num_egr_ports-1:0] guard_mask);
        qid_u        qid;
        int unsigned words;
        for (int i = 0; i < count; i++) begin
            qid.flat = qid_w'(random_below(num_queues));
            words    = random_below(4) + 1;
            if (!(guard_mask[qid.pp.port] && pend_len[qid.flat].size() >= fifo_depth)) begin
                enqueue(qid, words);
            end
        end
    endtask

    task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge dequeue_notification);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge dequeue_notification);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check_eq({cur_test, " pready"}, 1, pready, check_count, fail_count);
        @(negedge dequeue_notification);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic end_test(input string name, input int unsigned fails_before);
        $display("Test %s finished with %0d errors", name, fail_count - fails_before);
    endtask

    ////////////////////////////////////////
    // Done word monitor

    always @(negedge dequeue_notification) begin
        int q;
        int p;
        if (word_done_valid) begin
            q = word_done_qid.flat;
            p = word_done_qid.pp.port;
            if (watch_blocked && p == blocked_port) begin
                blocked_words++;
            end
            if (!port_busy[p]) begin
                if (pend_len[q].size() == 0) begin
                    $display("Word from queue %0d arrived with no packet pending", q);
                    fail_count++;
                end else begin
                    if (strict_on && p == strict_port) begin
                        check_eq({cur_test, " queue order"}, highest_queue(p), q,
                                 check_count, fail_count);
                    end
                    port_busy[p]  = 1'b1;
                    port_q[p]     = q;
                    port_words[p] = 0;
                end
            end
            if (port_busy[p]) begin
                check_eq({cur_test, " word queue"}, port_q[p], q, check_count, fail_count);
                port_words[p]++;
                check_eq({cur_test, " last flag"}, port_words[p] == pend_len[port_q[p]][0],
                         word_done_last, check_count, fail_count);
                // Resync on the model's packet end
                if (port_words[p] >= pend_len[port_q[p]][0]) begin
                    void'(pend_len[port_q[p]].pop_front());
                    port_busy[p] = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] rdata;
        logic        err;
        int unsigned fails_before;
        rst_n = 1'b0;
        enq_valid = 1'b0;
        enq_qid = '0;
        enq_len = '0;
        egr_buf_ready = '1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lcg_state = 32'he8d1_2744;
        repeat (5) @(negedge dequeue_notification);
        rst_n = 1'b1;

        cur_test = "reset";
        fails_before = fail_count;
        check_eq("reset word_done_valid", 0, word_done_valid, check_count, fail_count);
        apb_access(1'b0, reg_port_enable, 0, rdata, err);
        check_eq("reset enable", 32'hf, rdata, check_count, fail_count);
        for (int p = 0; p < num_egr_ports; p++) begin
            apb_access(1'b0, reg_words_sent_base + 8'(4 * p), 0, rdata, err);
            check_eq("reset counter", 0, rdata, check_count, fail_count);
            check_eq("reset counter pslverr", 0, err, check_count, fail_count);
        end
        end_test(cur_test, fails_before);

        cur_test = "integrity";
        fails_before = fail_count;
        load_random(40, '0);
        wait_idle('1);
        end_test(cur_test, fails_before);

        cur_test = "priority";
        fails_before = fail_count;
        apb_access(1'b1, reg_port_enable, 0, rdata, err);
        load_random(24, '1);
        strict_port = random_below(num_egr_ports);
        strict_on = 1'b1;
        apb_access(1'b1, reg_port_enable, 1 << strict_port, rdata, err);
        wait_idle(4'(1 << strict_port));
        strict_on = 1'b0;
        apb_access(1'b1, reg_port_enable, 32'hf, rdata, err);
        wait_idle('1);
        end_test(cur_test, fails_before);

        cur_test = "backpressure";
        fails_before = fail_count;
        blocked_port = random_below(num_egr_ports);
        load_random(12, '0);
        @(negedge dequeue_notification);
        egr_buf_ready[blocked_port] = 1'b0;
        // In-flight words finish within a few cycles
        repeat (8) @(negedge dequeue_notification);
        watch_blocked = 1'b1;
        blocked_words = 0;
        load_random(16, 4'(1 << blocked_port));
        wait_idle(~4'(1 << blocked_port));
        check_eq("backpressure blocked words", 0, blocked_words, check_count, fail_count);
        watch_blocked = 1'b0;
        egr_buf_ready = '1;
        wait_idle('1);
        end_test(cur_test, fails_before);

        cur_test = "registers";
        fails_before = fail_count;
        for (int p = 0; p < num_egr_ports; p++) begin
            apb_access(1'b0, reg_words_sent_base + 8'(4 * p), 0, rdata, err);
            check_eq("counter value", words_per_port[p] & 32'hffff, rdata,
                     check_count, fail_count);
        end
        apb_access(1'b0, 8'h08, 0, rdata, err);
        check_eq("unmapped read pslverr", 1, err, check_count, fail_count);
        apb_access(1'b0, 8'h20, 0, rdata, err);
        check_eq("unmapped read pslverr", 1, err, check_count, fail_count);
        apb_access(1'b1, reg_words_sent_base + 8'h4, 32'h1234, rdata, err);
        check_eq("counter write pslverr", 1, err, check_count, fail_count);
        apb_access(1'b0, reg_words_sent_base + 8'h4, 0, rdata, err);
        check_eq("counter after write", words_per_port[1] & 32'hffff, rdata,
                 check_count, fail_count);
        apb_access(1'b1, reg_port_enable, 32'hffff_fff5, rdata, err);
        apb_access(1'b0, reg_port_enable, 0, rdata, err);
        check_eq("enable mask bits", 32'h5, rdata, check_count, fail_count);
        apb_access(1'b1, reg_port_enable, 32'hf, rdata, err);
        end_test(cur_test, fails_before);

        $display("%0d checks, %0d failures", check_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
